/* verif/cdw_cases.txt */
# hit mode ddtp_ppn did caps nl0 nl1 dc_tc dc_iohgatp dc_ta dc_fsc err_beat expect
# All hex except expect (decimal: 0 update, 1 ignored, else cause), err_beat ff means none
0 2 12345 abcdef 1ff 0 0 3 8000000000012340 abc000 9000000000045678 ff 0
0 3 777 123456 1ff 40001 0 1 0 0 0 ff 0
0 4 a00 fedcba 1ff 40001 a9401 3 8000000000012340 abc000 9000000000045678 ff 0
0 4 3 ffffff 1ff 3ffffffffffc01 40001 1 0 0 0 ff 0
0 4 a00 fedcba 1ff 40000 a9401 3 8000000000012340 abc000 9000000000045678 ff 258
0 4 a00 fedcba 1ff 40001 00800000000a9401 1 0 0 0 ff 259
0 3 777 123456 1ff 40201 0 1 0 0 0 ff 259
0 2 12345 abcdef 0ff 0 0 3 8000000000012340 abc000 9000000000045678 ff 259
0 3 777 123456 1ff 40001 0 1 5000000000000000 0 0 ff 259
0 2 12345 abcdef 1fb 0 0 3 8000000000012340 abc000 9000000000045678 ff 259
0 2 12345 abcdef 1ff 0 0 b 0 0 0 ff 259
0 2 12345 abcdef 1ff 0 0 0 0 0 0 ff 258
0 2 12345 abcdef 1ff 0 0 3 8000000000012340 abc000 9000100000045678 ff 259
0 2 12345 abcdef 1ff 0 0 21 0 0 0 ff 259
0 2 12345 abcdef 1ff 0 0 3 8000000000012340 abc000 9000000000045678 2 268
0 4 a00 fedcba 1ff 40001 a9401 1 0 0 0 0 268
0 3 777 123456 1ff 40001 0 1 0 0 0 4 268
1 2 12345 abcdef 1ff 0 0 1 0 0 0 ff 1
0 0 12345 abcdef 1ff 0 0 1 0 0 0 ff 1
0 1 12345 abcdef 1ff 0 0 1 0 0 0 ff 1

/* flist.f */
source/cdw_pkg.sv
source/cdw_entry_check.sv
source/cdw_dc_collect.sv
source/cdw_walk_ctrl.sv
source/cdw_top.sv
verif/cdw_tb.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the walker testbench
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module cdw_tb -f flist.f -o cdw_sim \
    && ./obj_dir/cdw_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "cdw_tb passed" \
    || { echo "cdw_tb failed"; exit 1; }

/* verif/cdw_tb.sv */
// Testbench that replays device directory walk cases from a file against a modeled memory
`timescale 1ns/1ns

module cdw_tb import cdw_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic             clk_i;
    logic             rst_ni;
    mem_req_t         mem_req;
    mem_rsp_t         mem_rsp;
    logic             ddtc_access;
    logic             ddtc_hit;
    logic [DID_W-1:0] req_did;
    logic [PPN_W-1:0] ddtp_ppn;
    logic [3:0]       ddtp_mode;
    caps_t            caps;
    logic             update_dc;
    logic [DID_W-1:0] up_did;
    dc_t              up_dc;
    logic             cdw_active;
    logic             cdw_error;
    cause_e           cause;

    int               cases_run;
    int               beat_no;

    // Fields of the current case line
    logic [63:0] c_hit;
    logic [63:0] c_mode;
    logic [63:0] c_ppn;
    logic [63:0] c_did;
    logic [63:0] c_caps;
    logic [63:0] c_nl0;
    logic [63:0] c_nl1;
    logic [63:0] c_tc;
    logic [63:0] c_gatp;
    logic [63:0] c_ta;
    logic [63:0] c_fsc;
    logic [63:0] c_err;
    logic [63:0] c_exp;

    cdw_top cdw_top_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .mem_req_o     (mem_req),
        .mem_rsp_i     (mem_rsp),
        .ddtc_access_i (ddtc_access),
        .ddtc_hit_i    (ddtc_hit),
        .req_did_i     (req_did),
        .ddtp_ppn_i    (ddtp_ppn),
        .ddtp_mode_i   (ddtp_mode),
        .caps_i        (caps),
        .update_dc_o   (update_dc),
        .up_did_o      (up_did),
        .up_dc_o       (up_dc),
        .cdw_active_o  (cdw_active),
        .cdw_error_o   (cdw_error),
        .cause_o       (cause)
    );

    // 10 ns clock
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------
    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns, case %0d: %s, got 0x%0h, expected 0x%0h",
                     $time, cases_run, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns, case %0d: the walk never finished, no %s within %0d cycles",
                 $time, cases_run, what, TIMEOUT);
        $display(">>> FAIL");
        $fatal(1, "Stopping on a timeout");
    endtask

    // Table base plus the scaled device ID index of one level
    function automatic logic [63:0] expected_addr(input logic [63:0] ppn, input int lvl,
                                                  input logic [63:0] did);
        logic [63:0] off;
        if (lvl == 4) begin
            off = ((did >> 16) & 64'hff) * 64'd8;
        end else if (lvl == 3) begin
            off = ((did >> 7) & 64'h1ff) * 64'd8;
        end else begin
            off = (did & 64'h7f) * 64'd32;
        end
        return ppn * 64'd4096 + off;
    endfunction

    // DC doubleword for burst position idx
    function automatic logic [63:0] leaf_word(input int idx);
        case (idx)
            0:       return c_tc;
            1:       return c_gatp;
            2:       return c_ta;
            default: return c_fsc;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Stimulus and memory responder
    // ------------------------------------------------------------
    task automatic start_lookup();
        @(posedge clk_i);
        #1;
        ddtc_access = 1'b1;
        ddtc_hit    = c_hit[0];
        req_did     = c_did[DID_W-1:0];
        ddtp_ppn    = c_ppn[PPN_W-1:0];
        ddtp_mode   = c_mode[3:0];
        caps        = caps_t'(c_caps[8:0]);
        @(posedge clk_i);
        #1;
        ddtc_access = 1'b0;
        ddtc_hit    = 1'b0;
    endtask

    // Returns on a falling edge with a read request or a final pulse in view
    task automatic wait_event(output int waited);
        waited = 0;
        @(negedge clk_i);
        while (!(mem_req.ar_valid || update_dc || cdw_error)) begin
            waited++;
            if (waited > TIMEOUT) report_timeout("read request or final pulse");
            @(negedge clk_i);
        end
    endtask

    // Random AR back-pressure before one accepted address
    task automatic accept_request(input logic [63:0] exp_addr);
        repeat ($urandom % 4) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        mem_rsp.ar_ready = 1'b1;
        @(negedge clk_i);
        check_eq(64'(mem_req.ar_valid), 64'd1, "ar_valid held until ar_ready");
        check_eq(64'(mem_req.ar_addr), exp_addr, "ar_addr held until ar_ready");
        @(posedge clk_i);
        #1;
        mem_rsp.ar_ready = 1'b0;
    endtask

    task automatic send_beat(input logic [63:0] data, input logic last);
        int waited;
        repeat ($urandom % 4) @(posedge clk_i);
        @(posedge clk_i);
        #1;
        mem_rsp.r_valid = 1'b1;
        mem_rsp.r_data  = data;
        mem_rsp.r_last  = last;
        mem_rsp.r_err   = (beat_no == int'(c_err));
        waited = 0;
        @(negedge clk_i);
        while (!mem_req.r_ready) begin
            check_eq(64'(update_dc || cdw_error), 64'd0, "walk ended inside a burst");
            waited++;
            if (waited > TIMEOUT) report_timeout("r_ready");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        mem_rsp.r_valid = 1'b0;
        mem_rsp.r_last  = 1'b0;
        mem_rsp.r_err   = 1'b0;
        beat_no++;
    endtask

    task automatic run_walk();
        int          lvl;
        int          n_beats;
        int          b;
        int          idle_cycles;
        logic [63:0] ptr_ppn;
        logic [63:0] addr;
        logic [63:0] data;
        logic        done;
        lvl     = int'(c_mode);
        ptr_ppn = c_ppn;
        beat_no = 0;
        data    = 64'd0;
        done    = 1'b0;
        start_lookup();
        while (!done) begin
            wait_event(idle_cycles);
            if (update_dc || cdw_error) begin
                // Final pulse is due in the cycle right after the last accepted beat
                check_eq(64'(idle_cycles), 64'd0, "final pulse delayed after the last beat");
                done = 1'b1;
            end else begin
                // Levels count down to 2 for the DC burst
                check_eq(64'(lvl >= 2), 64'd1, "read request after the DC burst");
                addr = expected_addr(ptr_ppn, lvl, c_did);
                check_eq(64'(mem_req.ar_addr), addr, "ar_addr");
                check_eq(64'(mem_req.ar_len), (lvl == 2) ? 64'd3 : 64'd0, "ar_len");
                accept_request(addr);
                n_beats = (lvl == 2) ? 4 : 1;
                for (b = 0; b < n_beats; b++) begin
                    if (lvl == 2) begin
                        data = leaf_word(b);
                    end else begin
                        data = (int'(c_mode) == lvl) ? c_nl0 : c_nl1;
                    end
                    send_beat(data, b == n_beats - 1);
                end
                // Next table comes from the PPN field of the entry
                ptr_ppn = (data >> 10) & 64'hfff_ffff_ffff;
                lvl     = lvl - 1;
            end
        end

        check_eq(64'(cdw_active), 64'd1, "cdw_active_o during the final pulse");
        if (c_exp == 64'd0) begin
            check_eq(64'(update_dc), 64'd1, "update_dc_o");
            check_eq(64'(cdw_error), 64'd0, "cdw_error_o on a good walk");
            check_eq(64'(up_did), c_did, "up_did_o");
            check_eq(64'(up_dc.tc), c_tc, "up_dc_o tc");
            check_eq(64'(up_dc.iohgatp), c_gatp, "up_dc_o iohgatp");
            check_eq(64'(up_dc.ta), c_ta, "up_dc_o ta");
            check_eq(64'(up_dc.fsc), c_fsc, "up_dc_o fsc");
        end else begin
            check_eq(64'(cdw_error), 64'd1, "cdw_error_o");
            check_eq(64'(update_dc), 64'd0, "update_dc_o on a faulting walk");
            check_eq(64'(cause), c_exp, "cause_o");
        end
        // One-cycle pulse before the return to idle
        @(negedge clk_i);
        check_eq(64'(update_dc || cdw_error), 64'd0, "final pulse longer than one cycle");
        check_eq(64'(cdw_active), 64'd0, "cdw_active_o after the final pulse");
    endtask

    // Hits and bare or off modes start nothing
    task automatic check_ignored();
        start_lookup();
        repeat (5) begin
            @(negedge clk_i);
            check_eq(64'(mem_req.ar_valid), 64'd0, "ar_valid on an ignored lookup");
            check_eq(64'(cdw_active), 64'd0, "cdw_active_o on an ignored lookup");
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int    fd;
        int    code;
        int    fields;
        string line;
        cases_run = 0;
        beat_no   = 0;
        void'($urandom(67112));
        rst_ni      = 1'b0;
        mem_rsp     = '0;
        ddtc_access = 1'b0;
        ddtc_hit    = 1'b0;
        req_did     = '0;
        ddtp_ppn    = '0;
        ddtp_mode   = 4'd0;
        caps        = '0;

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_eq(64'(mem_req.ar_valid), 64'd0, "ar_valid in reset");
        check_eq(64'(mem_req.r_ready), 64'd0, "r_ready in reset");
        check_eq(64'(update_dc || cdw_error || cdw_active), 64'd0, "status outputs in reset");
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        fd = $fopen("verif/cdw_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file verif/cdw_cases.txt");
            $display(">>> FAIL");
            $fatal(1, "No case file");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %d",
                                 c_hit, c_mode, c_ppn, c_did, c_caps, c_nl0, c_nl1,
                                 c_tc, c_gatp, c_ta, c_fsc, c_err, c_exp);
                cases_run++;
                check_eq(64'(fields), 64'd13, "fields on a case line");
                if (c_hit[0] || c_mode < 64'd2 || c_mode > 64'd4) begin
                    check_ignored();
                end else begin
                    run_walk();
                end
            end
        end
        $fclose(fd);
        check_eq(64'(cases_run > 0), 64'd1, "no cases in the case file");

        $display(">>> PASS");
        $finish;
    end

endmodule

/* source/cdw_top.sv */
// Device directory walker top, joins the walk controller, DC collector and entry checker
`timescale 1ns/1ns

module cdw_top import cdw_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Memory read port
    output mem_req_t           mem_req_o,
    input  mem_rsp_t           mem_rsp_i,

    // DDTC lookup monitor
    input  logic               ddtc_access_i,
    input  logic               ddtc_hit_i,
    input  logic [DID_W-1:0]   req_did_i,

    // From the register map
    input  logic [PPN_W-1:0]   ddtp_ppn_i,
    input  logic [3:0]         ddtp_mode_i,
    input  caps_t              caps_i,

    // DDTC fill
    output logic               update_dc_o,
    output logic [DID_W-1:0]   up_did_o,
    output dc_t                up_dc_o,

    // Status and faults
    output logic               cdw_active_o,
    output logic               cdw_error_o,
    output cause_e             cause_o
);

    entry_kind_e kind;
    logic        take;
    logic        clear;
    logic [1:0]  beat_idx;
    logic        dc_loaded;
    logic        fault;
    cause_e      fault_cause;

    // ------------------------------------------------------------
    // Walk FSM and memory requests
    // ------------------------------------------------------------
    cdw_walk_ctrl walk_ctrl_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .mem_rsp_i     (mem_rsp_i),
        .mem_req_o     (mem_req_o),
        .ddtc_access_i (ddtc_access_i),
        .ddtc_hit_i    (ddtc_hit_i),
        .req_did_i     (req_did_i),
        .ddtp_ppn_i    (ddtp_ppn_i),
        .ddtp_mode_i   (ddtp_mode_i),
        .dc_loaded_i   (dc_loaded),
        .beat_idx_i    (beat_idx),
        .kind_o        (kind),
        .take_o        (take),
        .clear_o       (clear),
        .fault_i       (fault),
        .fault_cause_i (fault_cause),
        .update_dc_o   (update_dc_o),
        .up_did_o      (up_did_o),
        .cdw_active_o  (cdw_active_o),
        .cdw_error_o   (cdw_error_o),
        .cause_o       (cause_o)
    );

    // Leaf burst storage, also feeds the DDTC fill
    cdw_dc_collect dc_collect_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .take_i      (take),
        .clear_i     (clear),
        .r_data_i    (mem_rsp_i.r_data),
        .beat_idx_o  (beat_idx),
        .dc_loaded_o (dc_loaded),
        .dc_o        (up_dc_o)
    );

    // Field checks on the beat in flight
    cdw_entry_check entry_check_inst (
        .kind_i        (kind),
        .r_data_i      (mem_rsp_i.r_data),
        .caps_i        (caps_i),
        .stored_tc_i   (up_dc_o.tc),
        .fault_o       (fault),
        .fault_cause_o (fault_cause)
    );

endmodule

/* source/cdw_walk_ctrl.sv */
// Walk controller for the device directory, tracks levels and issues memory reads
`timescale 1ns/1ns

module cdw_walk_ctrl import cdw_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  mem_rsp_t           mem_rsp_i,
    output mem_req_t           mem_req_o,
    input  logic               ddtc_access_i,
    input  logic               ddtc_hit_i,
    input  logic [DID_W-1:0]   req_did_i,
    input  logic [PPN_W-1:0]   ddtp_ppn_i,
    input  logic [3:0]         ddtp_mode_i,
    input  logic               dc_loaded_i,
    input  logic [1:0]         beat_idx_i,
    output entry_kind_e        kind_o,
    output logic               take_o,
    output logic               clear_o,
    input  logic               fault_i,
    input  cause_e             fault_cause_i,
    output logic               update_dc_o,
    output logic [DID_W-1:0]   up_did_o,
    output logic               cdw_active_o,
    output logic               cdw_error_o,
    output cause_e             cause_o
);

    walk_state_e      state_q, state_n;
    ddt_level_e       lvl_q, lvl_n;
    logic [DID_W-1:0] did_q, did_n;
    logic [PLEN-1:0]  pptr_q, pptr_n;
    cause_e           cause_q, cause_n;
    // Set when a fault hits mid-burst and the rest must be drained
    logic             drain_q, drain_n;
    logic             ar_valid;
    logic             r_ready;
    nl_entry_t        nl;

    // Table base plus the device ID slice indexed at this level
    function automatic logic [PLEN-1:0] dir_ptr(input logic [PPN_W-1:0] ppn,
                                                input ddt_level_e       lvl,
                                                input logic [DID_W-1:0] did);
        logic [PLEN-1:0] ptr;
        case (lvl)
            LVL3:    ptr = {ppn, 1'b0, did[23:16], 3'b000};
            LVL2:    ptr = {ppn, did[15:7], 3'b000};
            default: ptr = {ppn, did[6:0], 5'b00000};   // 32-byte DC slots
        endcase
        return ptr;
    endfunction

    assign nl = nl_entry_t'(mem_rsp_i.r_data);

    // One beat for a directory entry, a 4-beat burst for the DC
    assign mem_req_o.ar_valid = ar_valid;
    assign mem_req_o.ar_addr  = pptr_q;
    assign mem_req_o.ar_len   = (lvl_q == LVL1) ? 8'd3 : 8'd0;
    assign mem_req_o.r_ready  = r_ready;

    assign cdw_active_o = (state_q != IDLE);
    assign up_did_o     = did_q;
    assign cause_o      = cause_q;

    // Beat kind for the checker
    always_comb begin
        kind_o = NL_ENTRY;
        if (state_q == LEAF) begin
            case (beat_idx_i)
                2'd0:    kind_o = DC_TC;
                2'd1:    kind_o = DC_IOHGATP;
                2'd2:    kind_o = DC_TA;
                default: kind_o = DC_FSC;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Walk FSM
    // ------------------------------------------------------------
    always_comb begin
        state_n     = state_q;
        lvl_n       = lvl_q;
        did_n       = did_q;
        pptr_n      = pptr_q;
        cause_n     = cause_q;
        drain_n     = drain_q;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        take_o      = 1'b0;
        clear_o     = 1'b0;
        update_dc_o = 1'b0;
        cdw_error_o = 1'b0;

        case (state_q)
            IDLE: begin
                // Only a DDTC miss with a 1, 2 or 3 level table starts a walk
                if (ddtc_access_i && !ddtc_hit_i && (ddtp_mode_i inside {4'd2, 4'd3, 4'd4})) begin
                    lvl_n   = ddt_level_e'(ddtp_mode_i[2:0]);
                    did_n   = req_did_i;
                    pptr_n  = dir_ptr(ddtp_ppn_i, lvl_n, req_did_i);
                    drain_n = 1'b0;
                    clear_o = 1'b1;
                    state_n = MEM_ACCESS;
                end
            end

            MEM_ACCESS: begin
                // Address and length stay put until accepted
                ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_n = (lvl_q == LVL1) ? LEAF : NON_LEAF;
                end
            end

            NON_LEAF: begin
                r_ready = 1'b1;
                if (mem_rsp_i.r_valid) begin
                    if (mem_rsp_i.r_err) begin
                        cause_n = DDT_DATA_CORRUPTION;
                        state_n = ERROR;
                    end else if (fault_i) begin
                        cause_n = fault_cause_i;
                        state_n = ERROR;
                    end else begin
                        // Descend one level
                        lvl_n   = (lvl_q == LVL3) ? LVL2 : LVL1;
                        pptr_n  = dir_ptr(nl.ppn, lvl_n, did_q);
                        state_n = MEM_ACCESS;
                    end
                end
            end

            LEAF: begin
                if (dc_loaded_i) begin
                    // All four words stored, fill the DDTC
                    update_dc_o = 1'b1;
                    state_n     = IDLE;
                end else begin
                    r_ready = 1'b1;
                    if (mem_rsp_i.r_valid) begin
                        take_o = 1'b1;
                        if (mem_rsp_i.r_err || fault_i) begin
                            cause_n = mem_rsp_i.r_err ? DDT_DATA_CORRUPTION : fault_cause_i;
                            drain_n = !mem_rsp_i.r_last;
                            state_n = ERROR;
                        end
                    end
                end
            end

            ERROR: begin
                // Swallow the rest of the burst before reporting
                r_ready = drain_q;
                if (drain_q) begin
                    if (mem_rsp_i.r_valid && mem_rsp_i.r_last) begin
                        drain_n = 1'b0;
                    end
                end else begin
                    cdw_error_o = 1'b1;
                    state_n     = IDLE;
                end
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            cause_q <= DDT_ENTRY_INVALID;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_n;
            lvl_q   <= lvl_n;
            cause_q <= cause_n;
            drain_q <= drain_n;
        end
    end

    // Walk context
    always_ff @(posedge clk_i) begin
        did_q  <= did_n;
        pptr_q <= pptr_n;
    end

endmodule

/* source/cdw_dc_collect.sv */
// DC collector, counts leaf beats and assembles the device context doublewords
`timescale 1ns/1ns

module cdw_dc_collect import cdw_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        take_i,
    input  logic        clear_i,
    input  logic [63:0] r_data_i,
    output logic [1:0]  beat_idx_o,
    output logic        dc_loaded_o,
    output dc_t         dc_o
);

    logic [1:0] beat_q;
    logic       loaded_q;
    dc_t        dc_q;

    assign beat_idx_o  = beat_q;
    assign dc_loaded_o = loaded_q;
    assign dc_o        = dc_q;

    // Beat counter, restarted for every walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q   <= 2'd0;
            loaded_q <= 1'b0;
        end else if (clear_i) begin
            beat_q   <= 2'd0;
            loaded_q <= 1'b0;
        end else if (take_i) begin
            beat_q <= beat_q + 2'd1;
            // Fourth beat completes the DC
            if (beat_q == 2'd3) begin
                loaded_q <= 1'b1;
            end
        end
    end

    // Burst order is tc, iohgatp, ta, fsc
    always_ff @(posedge clk_i) begin
        if (take_i) begin
            case (beat_q)
                2'd0:    dc_q.tc      <= dc_tc_t'(r_data_i);
                2'd1:    dc_q.iohgatp <= iohgatp_t'(r_data_i);
                2'd2:    dc_q.ta      <= dc_ta_t'(r_data_i);
                default: dc_q.fsc     <= fsc_t'(r_data_i);
            endcase
        end
    end

endmodule

/* source/cdw_entry_check.sv */
// Entry checker, flags invalid or misconfigured directory entries and DC words
`timescale 1ns/1ns

module cdw_entry_check import cdw_pkg::*; (
    input  entry_kind_e kind_i,
    input  logic [63:0] r_data_i,
    input  caps_t       caps_i,
    input  dc_tc_t      stored_tc_i,
    output logic        fault_o,
    output cause_e      fault_cause_o
);

    nl_entry_t nl;
    dc_tc_t    tc;
    iohgatp_t  gatp;
    dc_ta_t    ta;
    fsc_t      fsc;
    logic      tc_bad;
    logic      gatp_bad;
    logic      fsc_bad;

    // Views of the same beat
    assign nl   = nl_entry_t'(r_data_i);
    assign tc   = dc_tc_t'(r_data_i);
    assign gatp = iohgatp_t'(r_data_i);
    assign ta   = dc_ta_t'(r_data_i);
    assign fsc  = fsc_t'(r_data_i);

    // ------------------------------------------------------------
    // Per-word configuration rules
    // ------------------------------------------------------------
    // No process contexts here, so pdtv and dpe are never legal
    assign tc_bad = (|tc.reserved)
                 || (!caps_i.ats && (tc.en_ats || tc.en_pri || tc.prpr))
                 || (!tc.en_ats && (tc.en_pri || tc.prpr))
                 || (tc.t2gpa && (!caps_i.t2gpa || !tc.en_ats))
                 || (!caps_i.amo_hwad && (tc.sade || tc.gade))
                 || tc.pdtv || tc.dpe || tc.sxl;

    // Guest stage, x4 modes only; root must be 16 KiB aligned
    assign gatp_bad = !(gatp.mode inside {4'd0, 4'd8, 4'd9, 4'd10})
                   || ((gatp.mode == 4'd8) && !caps_i.sv39x4)
                   || ((gatp.mode == 4'd9) && !caps_i.sv48x4)
                   || ((gatp.mode == 4'd10) && !caps_i.sv57x4)
                   || (stored_tc_i.t2gpa && (gatp.mode == 4'd0))
                   || ((gatp.mode != 4'd0) && (|gatp.ppn[1:0]));

    // First stage holds iosatp
    assign fsc_bad = !(fsc.mode inside {4'd0, 4'd8, 4'd9, 4'd10})
                  || ((fsc.mode == 4'd8) && !caps_i.sv39)
                  || ((fsc.mode == 4'd9) && !caps_i.sv48)
                  || ((fsc.mode == 4'd10) && !caps_i.sv57)
                  || (|fsc.reserved);

    always_comb begin
        fault_o       = 1'b0;
        fault_cause_o = DDT_ENTRY_MISCONFIGURED;
        case (kind_i)
            NL_ENTRY: begin
                // Valid bit is checked ahead of reserved bits
                if (!nl.v) begin
                    fault_o       = 1'b1;
                    fault_cause_o = DDT_ENTRY_INVALID;
                end else if ((|nl.reserved_hi) || (|nl.reserved_lo)) begin
                    fault_o = 1'b1;
                end
            end
            DC_TC: begin
                if (!tc.v) begin
                    fault_o       = 1'b1;
                    fault_cause_o = DDT_ENTRY_INVALID;
                end else begin
                    fault_o = tc_bad;
                end
            end
            DC_IOHGATP: fault_o = gatp_bad;
            DC_TA:      fault_o = (|ta.reserved_hi) || (|ta.reserved_lo);
            DC_FSC:     fault_o = fsc_bad;
            default:    fault_o = 1'b0;
        endcase
    end

endmodule

/* source/cdw_pkg.sv */
// Device directory walker types, memory channel structs, entry layouts and fault causes
package cdw_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int unsigned PLEN    = 56;
    localparam int unsigned PPN_W   = 44;
    localparam int unsigned DID_W   = 24;
    localparam int unsigned CAUSE_W = 11;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        MEM_ACCESS,
        NON_LEAF,
        LEAF,
        ERROR
    } walk_state_e;

    // Walk level, encoded as the matching ddtp.MODE value
    typedef enum logic [2:0] {
        LVL1 = 3'd2,
        LVL2 = 3'd3,
        LVL3 = 3'd4
    } ddt_level_e;

    // Which word is on the read data bus
    typedef enum logic [2:0] {
        NL_ENTRY,
        DC_TC,
        DC_IOHGATP,
        DC_TA,
        DC_FSC
    } entry_kind_e;

    // Fault codes reported to the IOMMU fault queue
    typedef enum logic [CAUSE_W-1:0] {
        DDT_ENTRY_INVALID       = 11'd258,
        DDT_ENTRY_MISCONFIGURED = 11'd259,
        DDT_DATA_CORRUPTION     = 11'd268
    } cause_e;

    // ------------------------------------------------------------
    // Memory read port (AR and R channels only)
    // ------------------------------------------------------------
    typedef struct packed {
        logic            ar_valid;
        logic [PLEN-1:0] ar_addr;
        logic [7:0]      ar_len;     // beats minus one
        logic            r_ready;
    } mem_req_t;

    typedef struct packed {
        logic        ar_ready;
        logic        r_valid;
        logic [63:0] r_data;
        logic        r_last;
        logic        r_err;
    } mem_rsp_t;

    // ------------------------------------------------------------
    // Directory entry layouts
    // ------------------------------------------------------------
    typedef struct packed {
        logic [9:0]       reserved_hi;
        logic [PPN_W-1:0] ppn;
        logic [8:0]       reserved_lo;
        logic             v;
    } nl_entry_t;

    // Translation control, bit 0 first in the spec
    typedef struct packed {
        logic [51:0] reserved;
        logic        sxl;
        logic        sbe;
        logic        dpe;
        logic        sade;
        logic        gade;
        logic        prpr;
        logic        pdtv;
        logic        dtf;
        logic        t2gpa;
        logic        en_pri;
        logic        en_ats;
        logic        v;
    } dc_tc_t;

    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      gscid;
        logic [PPN_W-1:0] ppn;
    } iohgatp_t;

    typedef struct packed {
        logic [31:0] reserved_hi;
        logic [19:0] pscid;
        logic [11:0] reserved_lo;
    } dc_ta_t;

    typedef struct packed {
        logic [3:0]       mode;
        logic [15:0]      reserved;
        logic [PPN_W-1:0] ppn;
    } fsc_t;

    // Base format DC, tc sits in the low doubleword
    typedef struct packed {
        fsc_t     fsc;
        dc_ta_t   ta;
        iohgatp_t iohgatp;
        dc_tc_t   tc;
    } dc_t;

    // IOMMU capability bits relevant to DC checks
    typedef struct packed {
        logic ats;
        logic t2gpa;
        logic amo_hwad;
        logic sv39;
        logic sv48;
        logic sv57;
        logic sv39x4;
        logic sv48x4;
        logic sv57x4;
    } caps_t;

endpackage
